// File: include/icache_consts.svh
`ifndef ICACHE_CONSTS_SVH
`define ICACHE_CONSTS_SVH

// cache geometry that also works with 4 ways
`define ICACHE_WAYS      2
`define ICACHE_SETS      64
`define ICACHE_ADDR_W    32

// address slicing for 64-bit lines
`define ICACHE_INDEX_LSB 3
`define ICACHE_INDEX_W   6
`define ICACHE_TAG_LSB   9
`define ICACHE_TAG_W     23
`define ICACHE_WORD_BIT  2

// per-set age counter that saturates at all ones
`define ICACHE_AGE_W     3

`endif

// File: testbench/tb_icache.sv
`timescale 1ns/1ps
`include "icache_consts.svh"

module tb_icache;

    localparam int RESET_CYCLES = 16;
    localparam int RAND_REQ     = 60;
    localparam int NUM_REQ      = 7 + RAND_REQ;
    localparam int CYCLE_LIMIT  = 40 * NUM_REQ + RESET_CYCLES;

    logic                     clk = 1'b0;
    logic                     rst;
    logic                     i_req_valid;
    logic                     o_req_ready;
    logic [31:0]              i_req_addr;
    logic                     o_rsp_valid;
    logic                     i_rsp_ready;
    icache_pkg::icache_word_t o_rsp_data;
    logic                     o_mem_req_valid;
    logic                     i_mem_req_ready;
    logic [31:0]              o_mem_req_addr;
    logic                     i_mem_rsp_valid;
    icache_pkg::icache_line_t i_mem_rsp_data;

    int errors   = 0;
    int requests = 0;
    int hits     = 0;
    int cycles   = 0;
    int mem_reqs = 0;
    logic [31:0] mem_addr;
    logic        mreq_held = 1'b0;
    logic [31:0] held_addr;

    // reference copy of the cache state
    logic                    ref_valid [`ICACHE_WAYS][`ICACHE_SETS];
    icache_pkg::icache_tag_t ref_tag   [`ICACHE_WAYS][`ICACHE_SETS];
    int                      ref_age   [`ICACHE_WAYS][`ICACHE_SETS];

    always #5 clk = ~clk;

    icache_top u_icache_top (
        .clk             (clk),
        .rst             (rst),
        .i_req_valid     (i_req_valid),
        .o_req_ready     (o_req_ready),
        .i_req_addr      (i_req_addr),
        .o_rsp_valid     (o_rsp_valid),
        .i_rsp_ready     (i_rsp_ready),
        .o_rsp_data      (o_rsp_data),
        .o_mem_req_valid (o_mem_req_valid),
        .i_mem_req_ready (i_mem_req_ready),
        .o_mem_req_addr  (o_mem_req_addr),
        .i_mem_rsp_valid (i_mem_rsp_valid),
        .i_mem_rsp_data  (i_mem_rsp_data)
    );

    tb_mem_model u_mem (
        .clk         (clk),
        .rst         (rst),
        .i_req_valid (o_mem_req_valid),
        .o_req_ready (i_mem_req_ready),
        .i_req_addr  (o_mem_req_addr),
        .o_rsp_valid (i_mem_rsp_valid),
        .o_rsp_data  (i_mem_rsp_data)
    );

    task automatic mismatch(input string name, input logic [63:0] got, input logic [63:0] exp);
        errors++;
        $display("Error: %s got %0h expected %0h", name, got, exp);
    endtask

    task automatic failure(input string msg);
        errors++;
        $display("Error: %s", msg);
    endtask

    task automatic finish_run();
        $display("requests %0d, hits %0d, memory requests %0d, errors %0d",
                 requests, hits, mem_reqs, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    endtask

    function automatic logic [31:0] make_addr(input int tag, input int idx, input int word);
        return (tag << `ICACHE_TAG_LSB) | (idx << `ICACHE_INDEX_LSB) | (word << `ICACHE_WORD_BIT);
    endfunction

    function automatic int lookup_way(input logic [31:0] addr);
        int idx;
        idx = addr[`ICACHE_INDEX_LSB +: `ICACHE_INDEX_W];
        for (int w = 0; w < `ICACHE_WAYS; w++) begin
            if (ref_valid[w][idx] &&
                ref_tag[w][idx] == addr[`ICACHE_TAG_LSB +: `ICACHE_TAG_W]) begin
                return w;
            end
        end
        return -1;
    endfunction

    // invalid way first, then the oldest, lowest index on a tie
    function automatic int pick_victim(input int idx);
        int best;
        best = 0;
        for (int w = 0; w < `ICACHE_WAYS; w++) begin
            if (!ref_valid[w][idx]) begin
                return w;
            end
        end
        for (int w = 1; w < `ICACHE_WAYS; w++) begin
            if (ref_age[w][idx] > ref_age[best][idx]) begin
                best = w;
            end
        end
        return best;
    endfunction

    task automatic update_model(input logic [31:0] addr, input int way);
        int idx;
        int sel;
        idx = addr[`ICACHE_INDEX_LSB +: `ICACHE_INDEX_W];
        sel = way;
        if (sel < 0) begin
            sel                = pick_victim(idx);
            ref_valid[sel][idx] = 1'b1;
            ref_tag[sel][idx]   = addr[`ICACHE_TAG_LSB +: `ICACHE_TAG_W];
        end
        for (int w = 0; w < `ICACHE_WAYS; w++) begin
            if (w == sel) begin
                ref_age[w][idx] = 0;
            end else if (ref_age[w][idx] < 7) begin
                ref_age[w][idx]++;
            end
        end
    endtask

    // one fetch from a falling edge to the falling edge after its handshake
    task automatic fetch(input logic [31:0] addr, input bit bp, input int expect_hit);
        int          way;
        int          n;
        int          reqs_before;
        bit          ready;
        bit          done;
        logic [31:0] exp_data;
        way         = lookup_way(addr);
        exp_data    = addr ^ 32'h5A5A_0000;
        reqs_before = mem_reqs;
        requests++;
        i_req_valid = 1'b1;
        i_req_addr  = addr;
        while (!o_req_ready) @(negedge clk);
        @(negedge clk);
        i_req_valid = 1'b0;
        n = 1;
        while (!o_rsp_valid) begin
            @(negedge clk);
            n++;
        end
        assert (o_rsp_data == exp_data) else mismatch("o_rsp_data", o_rsp_data, exp_data);
        if (expect_hit >= 0) begin
            assert ((mem_reqs == reqs_before) == (expect_hit == 1))
            else failure("hit or miss differs from the replacement rule");
        end
        if (way >= 0) begin
            hits++;
            assert (n == 3) else failure("hit response not valid two cycles after acceptance");
            assert (mem_reqs == reqs_before) else failure("hit produced a memory request");
        end else begin
            assert (mem_reqs == reqs_before + 1)
            else failure("miss did not produce exactly one memory request");
            assert (mem_addr == {addr[31:3], 3'b000})
            else mismatch("o_mem_req_addr", mem_addr, {addr[31:3], 3'b000});
        end
        update_model(addr, way);
        done = 1'b0;
        while (!done) begin
            ready       = bp ? 1'($urandom_range(1, 0)) : 1'b1;
            i_rsp_ready = ready;
            @(negedge clk);
            if (ready) begin
                done = 1'b1;
            end else begin
                assert (o_rsp_valid) else failure("response dropped under back-pressure");
                assert (o_rsp_data == exp_data) else mismatch("o_rsp_data", o_rsp_data, exp_data);
                assert (!o_req_ready) else failure("fetch port opened while response pending");
            end
        end
        i_rsp_ready = 1'b1;
        assert (!o_rsp_valid) else failure("response still valid after its handshake");
    endtask

    // memory request watch on the rising edge where handshakes happen
    always @(posedge clk) begin
        if (rst) begin
            if (mreq_held) begin
                assert (o_mem_req_valid && o_mem_req_addr == held_addr)
                else failure("memory request changed before its handshake");
            end
            mreq_held = o_mem_req_valid && !i_mem_req_ready;
            held_addr = o_mem_req_addr;
            if (o_mem_req_valid && i_mem_req_ready) begin
                mem_reqs++;
                mem_addr = o_mem_req_addr;
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > CYCLE_LIMIT) begin
            failure("run did not finish within the cycle limit");
            finish_run();
        end
    end

    initial begin
        int seed_ret;
        seed_ret    = $urandom(32'h3047);
        rst         = 1'b0;
        i_req_valid = 1'b0;
        i_req_addr  = '0;
        i_rsp_ready = 1'b1;
        for (int w = 0; w < `ICACHE_WAYS; w++) begin
            for (int s = 0; s < `ICACHE_SETS; s++) begin
                ref_valid[w][s] = 1'b0;
                ref_tag[w][s]   = '0;
                ref_age[w][s]   = 0;
            end
        end
        repeat (RESET_CYCLES) begin
            @(negedge clk);
            assert (!o_req_ready && !o_rsp_valid && !o_mem_req_valid)
            else failure("output valid or ready high during reset");
        end
        rst = 1'b1;

        // fill two ways of set 5, then a third tag evicts the older one
        fetch(make_addr(1, 5, 0), 1'b0, 0);
        fetch(make_addr(1, 5, 1), 1'b0, 1);
        fetch(make_addr(2, 5, 0), 1'b0, 0);
        fetch(make_addr(1, 5, 0), 1'b0, 1);
        fetch(make_addr(3, 5, 1), 1'b0, 0);
        fetch(make_addr(1, 5, 1), 1'b0, 1);
        fetch(make_addr(2, 5, 0), 1'b0, 0);

        // small address pool so that hits and evictions mix
        for (int i = 0; i < RAND_REQ; i++) begin
            fetch(make_addr(8 + $urandom_range(3, 0), $urandom_range(7, 0),
                            $urandom_range(1, 0)), 1'b1, -1);
        end
        finish_run();
    end

endmodule

// File: testbench/tb_mem_model.sv
`timescale 1ns/1ps

// single-beat line memory with random accept and answer delays
module tb_mem_model (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     i_req_valid,
    output logic                     o_req_ready,
    input  logic [31:0]              i_req_addr,
    output logic                     o_rsp_valid,
    output icache_pkg::icache_line_t o_rsp_data
);

    // instruction word stored at byte address a
    function automatic logic [31:0] word_at(input logic [31:0] a);
        return a ^ 32'h5A5A_0000;
    endfunction

    // the word at the lower address sits in the low half
    function automatic icache_pkg::icache_line_t line_at(input logic [31:0] a);
        return {word_at(a + 32'd4), word_at(a)};
    endfunction

    initial begin
        int          delay;
        logic [31:0] addr_q;
        o_req_ready = 1'b0;
        o_rsp_valid = 1'b0;
        o_rsp_data  = '0;
        forever begin
            @(negedge clk);
            if (rst && i_req_valid) begin
                // accept after 0 to 3 cycles
                delay = $urandom_range(3, 0);
                repeat (delay) @(negedge clk);
                addr_q      = i_req_addr;
                o_req_ready = 1'b1;
                @(negedge clk);
                o_req_ready = 1'b0;
                // answer 1 to 8 cycles after the handshake
                delay = $urandom_range(8, 1);
                repeat (delay - 1) @(negedge clk);
                o_rsp_data  = line_at(addr_q);
                o_rsp_valid = 1'b1;
                @(negedge clk);
                o_rsp_valid = 1'b0;
            end
        end
    end

endmodule

// File: verilog/icache_ctrl.sv
`timescale 1ns/1ps
`include "icache_consts.svh"

module icache_ctrl (
    input  logic                                         clk,
    input  logic                                         rst,
    input  logic                                         i_req_valid,
    output logic                                         o_req_ready,
    input  logic [`ICACHE_ADDR_W-1:0]                    i_req_addr,
    output logic                                         o_mem_req_valid,
    input  logic                                         i_mem_req_ready,
    output logic [`ICACHE_ADDR_W-1:0]                    o_mem_req_addr,
    input  logic                                         i_mem_rsp_valid,
    input  icache_pkg::icache_line_t                     i_mem_rsp_data,
    output logic                                         o_rd_en,
    output logic [`ICACHE_INDEX_W-1:0]                   o_index,
    output icache_pkg::icache_tag_t                      o_tag,
    output logic [`ICACHE_WAYS-1:0]                      o_fill_we,
    output icache_pkg::icache_line_t                     o_fill_line,
    output logic                                         o_touch,
    input  logic [`ICACHE_WAYS-1:0]                      i_way_hit,
    input  logic [`ICACHE_WAYS-1:0]                      i_way_valid,
    input  icache_pkg::icache_age_t [`ICACHE_WAYS-1:0]   i_way_age,
    output logic                                         o_rsp_load,
    output logic                                         o_rsp_fill,
    output logic                                         o_word_sel,
    input  logic                                         i_rsp_busy
);

    typedef enum logic [1:0] {IDLE, LOOKUP, MREQ, WAIT} state_t;

    state_t                      state;
    state_t                      state_nxt;
    logic [`ICACHE_ADDR_W-1:0]   addr_q;
    logic                        cmp_q;
    logic                        live_q;
    logic                        accept;
    logic                        any_hit;
    logic                        hit_now;
    logic                        fill;
    logic                        found;
    icache_pkg::icache_age_t     best_age;
    logic [`ICACHE_WAYS-1:0]     victim;
    logic [`ICACHE_WAYS-1:0]     victim_q;

    // live_q keeps the fetch port closed for the first cycle out of reset
    assign o_req_ready = live_q && (state == IDLE) && !i_rsp_busy;
    assign accept      = i_req_valid && o_req_ready;
    assign any_hit     = |i_way_hit;

    // LOOKUP spends one cycle on the RAM read and one on the compare (cmp_q)
    assign hit_now = (state == LOOKUP) && cmp_q && any_hit;
    assign fill    = (state == WAIT) && i_mem_rsp_valid;

    assign o_rd_en         = (state == LOOKUP) && !cmp_q;
    assign o_index         = addr_q[`ICACHE_INDEX_LSB +: `ICACHE_INDEX_W];
    assign o_tag           = addr_q[`ICACHE_TAG_LSB +: `ICACHE_TAG_W];
    assign o_word_sel      = addr_q[`ICACHE_WORD_BIT];
    assign o_mem_req_valid = (state == MREQ);
    assign o_mem_req_addr  = {addr_q[`ICACHE_ADDR_W-1:`ICACHE_INDEX_LSB],
                              {`ICACHE_INDEX_LSB{1'b0}}};
    assign o_fill_we       = {`ICACHE_WAYS{fill}} & victim_q;
    assign o_fill_line     = i_mem_rsp_data;
    assign o_touch         = hit_now || fill;
    assign o_rsp_load      = hit_now || fill;
    assign o_rsp_fill      = fill;

    // victim is the first invalid way, else the oldest with the lowest index on a tie
    always_comb begin
        victim   = '0;
        found    = 1'b0;
        best_age = i_way_age[0];
        for (int w = 0; w < `ICACHE_WAYS; w++) begin
            if (!found && !i_way_valid[w]) begin
                victim[w] = 1'b1;
                found     = 1'b1;
            end
        end
        if (!found) begin
            victim[0] = 1'b1;
            for (int w = 1; w < `ICACHE_WAYS; w++) begin
                if (i_way_age[w] > best_age) begin
                    victim    = '0;
                    victim[w] = 1'b1;
                    best_age  = i_way_age[w];
                end
            end
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE:    if (accept) state_nxt = LOOKUP;
            LOOKUP:  if (cmp_q) state_nxt = any_hit ? IDLE : MREQ;
            MREQ:    if (i_mem_req_ready) state_nxt = WAIT;
            WAIT:    if (i_mem_rsp_valid) state_nxt = IDLE;
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state  <= IDLE;
            cmp_q  <= 1'b0;
            live_q <= 1'b0;
        end else begin
            state  <= state_nxt;
            cmp_q  <= (state == LOOKUP) && !cmp_q;
            live_q <= 1'b1;
        end
    end

    // request address and chosen victim for the pending miss
    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q <= i_req_addr;
        end
        if ((state == LOOKUP) && cmp_q && !any_hit) begin
            victim_q <= victim;
        end
    end

endmodule

// File: verilog/icache_pkg.sv
`include "icache_consts.svh"

package icache_pkg;

    // stored tag from address bits 31..9
    typedef logic [`ICACHE_TAG_W-1:0] icache_tag_t;

    // one cache line holding two instructions
    // the word at an address with bit 2 clear is the low half
    typedef logic [63:0] icache_line_t;

    // one instruction
    typedef logic [31:0] icache_word_t;

    // saturating per-set age of a way
    typedef logic [`ICACHE_AGE_W-1:0] icache_age_t;

endpackage

// File: verilog/icache_resp.sv
`timescale 1ns/1ps
`include "icache_consts.svh"

module icache_resp (
    input  logic                                          clk,
    input  logic                                          rst,
    input  logic                                          i_load,
    input  logic                                          i_fill,
    input  icache_pkg::icache_line_t                      i_fill_line,
    input  logic                                          i_word_sel,
    input  logic [`ICACHE_WAYS-1:0]                       i_way_hit,
    input  icache_pkg::icache_line_t [`ICACHE_WAYS-1:0]   i_way_line,
    output logic                                          o_rsp_valid,
    input  logic                                          i_rsp_ready,
    output icache_pkg::icache_word_t                      o_rsp_data,
    output logic                                          o_busy
);

    localparam int WORD_W = $bits(icache_pkg::icache_word_t);

    icache_pkg::icache_line_t hit_line;
    icache_pkg::icache_line_t sel_line;
    icache_pkg::icache_word_t sel_word;
    logic                     valid_q;

    // at most one way hits, so an OR of the gated lines is the mux
    always_comb begin
        hit_line = '0;
        for (int w = 0; w < `ICACHE_WAYS; w++) begin
            if (i_way_hit[w]) begin
                hit_line = hit_line | i_way_line[w];
            end
        end
    end

    // on a miss the word comes straight from the fill data
    assign sel_line = i_fill ? i_fill_line : hit_line;
    assign sel_word = i_word_sel ? sel_line[WORD_W +: WORD_W] : sel_line[0 +: WORD_W];

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            valid_q <= 1'b0;
        end else if (i_load) begin
            valid_q <= 1'b1;
        end else if (i_rsp_ready) begin
            valid_q <= 1'b0;
        end
    end

    // held stable until the handshake
    always_ff @(posedge clk) begin
        if (i_load) begin
            o_rsp_data <= sel_word;
        end
    end

    assign o_rsp_valid = valid_q;
    assign o_busy      = valid_q;

endmodule

// File: verilog/icache_sram.sv
`timescale 1ns/1ps
`include "icache_consts.svh"

// single-port RAM with registered read and write-through on the read port
module icache_sram #(
    parameter type T = logic
) (
    input  logic                       clk,
    input  logic                       i_en,
    input  logic                       i_we,
    input  logic [`ICACHE_INDEX_W-1:0] i_addr,
    input  T                           i_wdata,
    output T                           o_rdata
);

    T mem [`ICACHE_SETS];

    // read data only changes on an enabled cycle
    always_ff @(posedge clk) begin
        if (i_en) begin
            if (i_we) begin
                mem[i_addr] <= i_wdata;
                o_rdata     <= i_wdata;
            end else begin
                o_rdata <= mem[i_addr];
            end
        end
    end

endmodule

// File: verilog/icache_top.sv
`timescale 1ns/1ps
`include "icache_consts.svh"

module icache_top (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       i_req_valid,
    output logic                       o_req_ready,
    input  logic [`ICACHE_ADDR_W-1:0]  i_req_addr,
    output logic                       o_rsp_valid,
    input  logic                       i_rsp_ready,
    output icache_pkg::icache_word_t   o_rsp_data,
    output logic                       o_mem_req_valid,
    input  logic                       i_mem_req_ready,
    output logic [`ICACHE_ADDR_W-1:0]  o_mem_req_addr,
    input  logic                       i_mem_rsp_valid,
    input  icache_pkg::icache_line_t   i_mem_rsp_data
);

    logic                                        rd_en;
    logic [`ICACHE_INDEX_W-1:0]                  index;
    icache_pkg::icache_tag_t                     tag;
    logic [`ICACHE_WAYS-1:0]                     fill_we;
    icache_pkg::icache_line_t                    fill_line;
    logic                                        touch;
    logic [`ICACHE_WAYS-1:0]                     way_hit;
    logic [`ICACHE_WAYS-1:0]                     way_valid;
    icache_pkg::icache_age_t [`ICACHE_WAYS-1:0]  way_age;
    icache_pkg::icache_line_t [`ICACHE_WAYS-1:0] way_line;
    logic                                        rsp_load;
    logic                                        rsp_fill;
    logic                                        word_sel;
    logic                                        rsp_busy;

    icache_ctrl u_ctrl (
        .clk             (clk),
        .rst             (rst),
        .i_req_valid     (i_req_valid),
        .o_req_ready     (o_req_ready),
        .i_req_addr      (i_req_addr),
        .o_mem_req_valid (o_mem_req_valid),
        .i_mem_req_ready (i_mem_req_ready),
        .o_mem_req_addr  (o_mem_req_addr),
        .i_mem_rsp_valid (i_mem_rsp_valid),
        .i_mem_rsp_data  (i_mem_rsp_data),
        .o_rd_en         (rd_en),
        .o_index         (index),
        .o_tag           (tag),
        .o_fill_we       (fill_we),
        .o_fill_line     (fill_line),
        .o_touch         (touch),
        .i_way_hit       (way_hit),
        .i_way_valid     (way_valid),
        .i_way_age       (way_age),
        .o_rsp_load      (rsp_load),
        .o_rsp_fill      (rsp_fill),
        .o_word_sel      (word_sel),
        .i_rsp_busy      (rsp_busy)
    );

    for (genvar w = 0; w < `ICACHE_WAYS; w++) begin : g_way
        icache_way u_way (
            .clk         (clk),
            .rst         (rst),
            .i_rd_en     (rd_en),
            .i_index     (index),
            .i_tag       (tag),
            .i_fill_we   (fill_we[w]),
            .i_fill_line (fill_line),
            .i_touch     (touch),
            .o_hit       (way_hit[w]),
            .o_valid     (way_valid[w]),
            .o_age       (way_age[w]),
            .o_line      (way_line[w])
        );
    end

    icache_resp u_resp (
        .clk         (clk),
        .rst         (rst),
        .i_load      (rsp_load),
        .i_fill      (rsp_fill),
        .i_fill_line (fill_line),
        .i_word_sel  (word_sel),
        .i_way_hit   (way_hit),
        .i_way_line  (way_line),
        .o_rsp_valid (o_rsp_valid),
        .i_rsp_ready (i_rsp_ready),
        .o_rsp_data  (o_rsp_data),
        .o_busy      (rsp_busy)
    );

endmodule

// File: verilog/icache_way.sv
`timescale 1ns/1ps
`include "icache_consts.svh"

module icache_way (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       i_rd_en,
    input  logic [`ICACHE_INDEX_W-1:0] i_index,
    input  icache_pkg::icache_tag_t    i_tag,
    input  logic                       i_fill_we,
    input  icache_pkg::icache_line_t   i_fill_line,
    input  logic                       i_touch,
    output logic                       o_hit,
    output logic                       o_valid,
    output icache_pkg::icache_age_t    o_age,
    output icache_pkg::icache_line_t   o_line
);

    logic [`ICACHE_SETS-1:0]    valid;
    icache_pkg::icache_age_t    age [`ICACHE_SETS];
    logic [`ICACHE_INDEX_W-1:0] index_q;
    icache_pkg::icache_tag_t    tag_rd;
    logic                       ram_en;

    // a fill writes tag and line at once
    assign ram_en = i_rd_en | i_fill_we;

    icache_sram #(
        .T (icache_pkg::icache_tag_t)
    ) u_tag_ram (
        .clk     (clk),
        .i_en    (ram_en),
        .i_we    (i_fill_we),
        .i_addr  (i_index),
        .i_wdata (i_tag),
        .o_rdata (tag_rd)
    );

    icache_sram #(
        .T (icache_pkg::icache_line_t)
    ) u_data_ram (
        .clk     (clk),
        .i_en    (ram_en),
        .i_we    (i_fill_we),
        .i_addr  (i_index),
        .i_wdata (i_fill_line),
        .o_rdata (o_line)
    );

    // index of the set whose RAM data is on the outputs
    always_ff @(posedge clk) begin
        if (i_rd_en) begin
            index_q <= i_index;
        end
    end

    assign o_valid = valid[index_q];
    assign o_age   = age[index_q];
    assign o_hit   = o_valid && (tag_rd == i_tag);

    // touched way goes young, the others in the set age by one
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            valid <= '0;
            for (int s = 0; s < `ICACHE_SETS; s++) begin
                age[s] <= '0;
            end
        end else begin
            if (i_fill_we) begin
                valid[i_index] <= 1'b1;
            end
            if (i_touch) begin
                if (o_hit || i_fill_we) begin
                    age[i_index] <= '0;
                end else if (age[i_index] != '1) begin
                    age[i_index] <= age[i_index] + 1'b1;
                end
            end
        end
    end

endmodule

// File: vlog.f
+incdir+include
verilog/icache_pkg.sv
verilog/icache_sram.sv
verilog/icache_way.sv
verilog/icache_ctrl.sv
verilog/icache_resp.sv
verilog/icache_top.sv
testbench/tb_mem_model.sv
testbench/tb_icache.sv
